//--- addr_map_macros.svh
// #########################################################
// Size definitions shared by the address map router RTL
// Include this header wherever a bus width or a table size
// is needed
// #########################################################
`ifndef ADDR_MAP_MACROS_SVH
`define ADDR_MAP_MACROS_SVH

// Byte address width seen by the initiator and the rule table
`define ADDR_W 16
// Data word width of every request and response
`define DATA_W 32
// Number of memory targets behind the router
`define N_TGT 4
// Number of programmable address rules
`define N_RULES 4
// Words held by each memory target
`define TGT_WORDS 16
// Depth of the in-order response queue
`define ORD_DEPTH 4

`endif

//--- rtl/addr_map_pkg.sv
// #########################################################
// Types for the address map router
// Holds the rule word views, the rule table entry and the
// target index type used across the design
// #########################################################
`include "addr_map_macros.svh"

package addr_map_pkg;

  // Target index, sized for the number of targets
  typedef logic [$clog2(`N_TGT)-1:0] tgt_idx_t;

  // Range view of a rule word, start included and end excluded
  typedef struct packed {
    logic [`ADDR_W-1:0] start_addr;
    logic [`ADDR_W-1:0] end_addr;
  } range_rule_t;

  // NAPOT view of the same bits, base compared under the mask
  typedef struct packed {
    logic [`ADDR_W-1:0] base;
    logic [`ADDR_W-1:0] mask;
  } napot_rule_t;

  // One rule word, decoded as a range or as a NAPOT region
  typedef union packed {
    range_rule_t range_r;
    napot_rule_t napot_r;
  } rule_u;

  // The napot bit picks which view of the rule word applies
  typedef struct packed {
    logic     valid;
    logic     napot;
    tgt_idx_t idx;
    rule_u    rule;
  } rule_entry_t;

endpackage

//--- rtl/tgt_link_if.sv
// #########################################################
// Request and response link between the router and one
// memory target, with one modport per side
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

interface tgt_link_if;

  // Request channel, the address is a word offset inside the target
  logic                          req_valid;
  logic                          req_ready;
  logic                          req_we;
  logic [$clog2(`TGT_WORDS)-1:0] req_addr;
  logic [`DATA_W-1:0]            req_wdata;

  // Response channel
  logic                          rsp_valid;
  logic                          rsp_ready;
  logic [`DATA_W-1:0]            rsp_rdata;

  // The steer side issues requests
  modport steer (output req_valid, req_we, req_addr, req_wdata, input req_ready);

  // The target serves requests and produces responses
  modport target (
    input  req_valid, req_we, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata
  );

  // The merge side collects responses
  modport merge (input rsp_valid, rsp_rdata, output rsp_ready);

endinterface

//--- rtl/addr_decode.sv
// #########################################################
// Combinational address decoder over the rule table
// Each rule is a range or a NAPOT region by its own mode
// bit, and the highest matching table position wins
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

module addr_decode (
  input  logic [`ADDR_W-1:0]        addr_i,
  input  addr_map_pkg::rule_entry_t rules_i [`N_RULES],
  input  logic                      en_default_i,
  input  addr_map_pkg::tgt_idx_t    default_idx_i,
  output addr_map_pkg::tgt_idx_t    idx_o,
  output logic                      dec_error_o
);

  // One bit per rule that covers the address
  logic [`N_RULES-1:0] hit;

  // Match every rule through the view its mode bit selects
  always_comb begin
    for (int i = 0; i < `N_RULES; i++) begin
      if (rules_i[i].napot) begin
        // Only the bits set in the mask take part in the compare
        hit[i] = (addr_i & rules_i[i].rule.napot_r.mask) ==
                 (rules_i[i].rule.napot_r.base & rules_i[i].rule.napot_r.mask);
      end else begin
        // Half-open range, the end address itself lies outside
        hit[i] = (addr_i >= rules_i[i].rule.range_r.start_addr) &&
                 (addr_i <  rules_i[i].rule.range_r.end_addr);
      end
      // An invalid entry never matches
      hit[i] = hit[i] & rules_i[i].valid;
    end
  end

  // Priority pick, walking upward so the highest position overrides lower ones
  always_comb begin
    // Without any hit the default target applies when it is enabled
    idx_o       = en_default_i ? default_idx_i : '0;
    dec_error_o = ~en_default_i;
    for (int i = 0; i < `N_RULES; i++) begin
      if (hit[i]) begin
        idx_o       = rules_i[i].idx;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

//--- rtl/req_steer.sv
// #########################################################
// Request side of the router
// Holds the rule table, decodes each initiator request and
// sends it to one target link or marks it as an error
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

module req_steer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  logic                          req_we_i,
  input  logic [`ADDR_W-1:0]            req_addr_i,
  input  logic [`DATA_W-1:0]            req_wdata_i,
  input  logic                          cfg_we_i,
  input  logic [$clog2(`N_RULES)-1:0]   cfg_sel_i,
  input  addr_map_pkg::rule_entry_t     cfg_entry_i,
  input  logic                          en_default_i,
  input  addr_map_pkg::tgt_idx_t        default_idx_i,
  tgt_link_if.steer                     tgt [`N_TGT],
  output logic                          ord_push_o,
  output addr_map_pkg::tgt_idx_t        ord_idx_o,
  output logic                          ord_err_o,
  input  logic                          ord_full_i
);

  import addr_map_pkg::*;

  // Word offset width inside a target and the byte lane bits below it
  localparam int unsigned OFF_W  = $clog2(`TGT_WORDS);
  localparam int unsigned BYTE_W = $clog2(`DATA_W/8);

  logic [`N_RULES-1:0] tbl_valid;
  rule_entry_t         tbl_q    [`N_RULES];
  rule_entry_t         tbl_rules [`N_RULES];
  tgt_idx_t            dec_idx;
  logic                dec_err;
  logic [`N_TGT-1:0]   tgt_ready;

  // Valid bits are control state and come out of reset cleared
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tbl_valid <= '0;
    end else if (cfg_we_i) begin
      tbl_valid[cfg_sel_i] <= cfg_entry_i.valid;
    end
  end

  // Rule payload is written as a whole, valid is taken from tbl_valid
  always_ff @(posedge clk_i) begin
    if (cfg_we_i) begin
      tbl_q[cfg_sel_i] <= cfg_entry_i;
    end
  end

  // Merge the reset valid bits back into the entries seen by the decoder
  always_comb begin
    for (int i = 0; i < `N_RULES; i++) begin
      tbl_rules[i]       = tbl_q[i];
      tbl_rules[i].valid = tbl_valid[i];
    end
  end

  addr_decode u_decode (
    .addr_i        (req_addr_i),
    .rules_i       (tbl_rules),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .idx_o         (dec_idx),
    .dec_error_o   (dec_err)
  );

  // Drive each link, only the decoded one sees a valid request
  for (genvar g = 0; g < `N_TGT; g++) begin : g_link
    assign tgt[g].req_valid = req_valid_i & ~ord_full_i & ~dec_err & (dec_idx == g);
    assign tgt[g].req_we    = req_we_i;
    assign tgt[g].req_addr  = req_addr_i[OFF_W+BYTE_W-1:BYTE_W];
    assign tgt[g].req_wdata = req_wdata_i;
    assign tgt_ready[g]     = tgt[g].req_ready;
  end

  // An error request needs only room in the order queue
  assign req_ready_o = ~ord_full_i & (dec_err | tgt_ready[dec_idx]);

  // Every accepted request records where its response will come from
  assign ord_push_o = req_valid_i & req_ready_o;
  assign ord_idx_o  = dec_idx;
  assign ord_err_o  = dec_err;

endmodule

//--- rtl/mem_target.sv
// #########################################################
// Word-addressed memory target
// Serves one request at a time and holds its response in a
// register until the router takes it
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

module mem_target (
  input  logic       clk_i,
  input  logic       rst_n_i,
  tgt_link_if.target link
);

  logic [`DATA_W-1:0] mem [`TGT_WORDS];
  logic               rsp_valid_q;
  logic [`DATA_W-1:0] rsp_rdata_q;
  logic               req_fire;

  // A new request fits when the response slot is free or drains this cycle
  assign link.req_ready = ~rsp_valid_q | link.rsp_ready;
  assign req_fire       = link.req_valid & link.req_ready;

  // Response valid flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (link.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Storage and response data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (link.req_we) begin
        mem[link.req_addr] <= link.req_wdata;
        // Writes answer with zero data
        rsp_rdata_q        <= '0;
      end else begin
        rsp_rdata_q        <= mem[link.req_addr];
      end
    end
  end

  assign link.rsp_valid = rsp_valid_q;
  assign link.rsp_rdata = rsp_rdata_q;

endmodule

//--- rtl/rsp_merge.sv
// #########################################################
// Response side of the router
// Keeps the destinations of issued requests in order and
// forwards the head response, target or error, upstream
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

module rsp_merge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   ord_push_i,
  input  addr_map_pkg::tgt_idx_t ord_idx_i,
  input  logic                   ord_err_i,
  output logic                   ord_full_o,
  tgt_link_if.merge              tgt [`N_TGT],
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`DATA_W-1:0]     rsp_rdata_o,
  output logic                   rsp_err_o
);

  import addr_map_pkg::*;

  localparam int unsigned PTR_W = $clog2(`ORD_DEPTH);

  tgt_idx_t           q_idx [`ORD_DEPTH];
  logic               q_err [`ORD_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;
  logic               empty;
  logic               pop;
  tgt_idx_t           head_idx;
  logic               head_err;
  logic [`N_TGT-1:0]  tgt_valid;
  logic [`DATA_W-1:0] tgt_rdata [`N_TGT];

  assign empty      = (count == '0);
  assign ord_full_o = (count == `ORD_DEPTH);
  assign head_idx   = q_idx[rd_ptr];
  assign head_err   = q_err[rd_ptr];

  // Queue pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (ord_push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + ord_push_i - pop;
    end
  end

  // Destination entries
  always_ff @(posedge clk_i) begin
    if (ord_push_i) begin
      q_idx[wr_ptr] <= ord_idx_i;
      q_err[wr_ptr] <= ord_err_i;
    end
  end

  // Gather the target responses, and only the head target gets the ready
  for (genvar g = 0; g < `N_TGT; g++) begin : g_rsp
    assign tgt_valid[g]     = tgt[g].rsp_valid;
    assign tgt_rdata[g]     = tgt[g].rsp_rdata;
    assign tgt[g].rsp_ready = rsp_ready_i & ~empty & ~head_err & (head_idx == g);
  end

  // An error head answers at once with zero data
  assign rsp_valid_o = ~empty & (head_err | tgt_valid[head_idx]);
  assign rsp_err_o   = ~empty & head_err;
  assign rsp_rdata_o = (empty | head_err) ? '0 : tgt_rdata[head_idx];

  assign pop = rsp_valid_o & rsp_ready_i;

endmodule

//--- rtl/addr_map_top.sv
// #########################################################
// Top level of the address map router
// One initiator, a programmable rule table and N_TGT memory
// targets, responses return in request order
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

module addr_map_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic                        req_we_i,
  input  logic [`ADDR_W-1:0]          req_addr_i,
  input  logic [`DATA_W-1:0]          req_wdata_i,
  output logic                        rsp_valid_o,
  input  logic                        rsp_ready_i,
  output logic [`DATA_W-1:0]          rsp_rdata_o,
  output logic                        rsp_err_o,
  input  logic                        cfg_we_i,
  input  logic [$clog2(`N_RULES)-1:0] cfg_sel_i,
  input  addr_map_pkg::rule_entry_t   cfg_entry_i,
  input  logic                        en_default_i,
  input  addr_map_pkg::tgt_idx_t      default_idx_i
);

  import addr_map_pkg::*;

  // Order queue handshake between the two router halves
  logic     ord_push;
  tgt_idx_t ord_idx;
  logic     ord_err;
  logic     ord_full;

  tgt_link_if link [`N_TGT] ();

  req_steer u_steer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_we_i      (req_we_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_sel_i     (cfg_sel_i),
    .cfg_entry_i   (cfg_entry_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .tgt           (link),
    .ord_push_o    (ord_push),
    .ord_idx_o     (ord_idx),
    .ord_err_o     (ord_err),
    .ord_full_i    (ord_full)
  );

  // One memory per link
  for (genvar g = 0; g < `N_TGT; g++) begin : g_tgt
    mem_target u_mem (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .link    (link[g])
    );
  end

  rsp_merge u_merge (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ord_push_i  (ord_push),
    .ord_idx_i   (ord_idx),
    .ord_err_i   (ord_err),
    .ord_full_o  (ord_full),
    .tgt         (link),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
  );

endmodule

//--- dv/tb_addr_map.sv
// #########################################################
// Self-checking testbench for the address map router
// Drives rule setups and requests into the top level and
// checks every response against a reference decoder and a
// memory model, run as the top module of the simulation
// #########################################################
`timescale 1ns/100ps
`include "addr_map_macros.svh"

module tb_addr_map;

  import addr_map_pkg::*;

  localparam int BYTES  = `DATA_W / 8;
  localparam int N_RAND = 200;
  // Fill and read-back of every word, the short directed tests, then the random run,
  // each request allowed a generous number of cycles under back-pressure
  localparam int MAX_CYCLES = 16 * (2 * `N_TGT * `TGT_WORDS + 40 + N_RAND);

  logic clk_i, rst_n_i, req_valid_i, req_ready_o, req_we_i, rsp_valid_o, rsp_ready_i;
  logic rsp_err_o, cfg_we_i, en_default_i;
  logic [`ADDR_W-1:0]          req_addr_i;
  logic [`DATA_W-1:0]          req_wdata_i, rsp_rdata_o;
  logic [$clog2(`N_RULES)-1:0] cfg_sel_i;
  rule_entry_t                 cfg_entry_i;
  tgt_idx_t                    default_idx_i;

  // Testbench copy of the rule table, kept in plain arrays
  logic               tb_valid [`N_RULES];
  logic               tb_napot [`N_RULES];
  tgt_idx_t           tb_idx [`N_RULES];
  logic [`ADDR_W-1:0] tb_a [`N_RULES];
  logic [`ADDR_W-1:0] tb_b [`N_RULES];
  logic [`DATA_W-1:0] model_mem [`N_TGT][`TGT_WORDS];

  // Expected responses in request order
  logic [`DATA_W-1:0] exp_data [$];
  logic               exp_err [$];
  int                 exp_cycle [$];
  int  cycle, errors, checks, test_base, n_tests, seed;
  logic chk_lat, sending;

  addr_map_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // Returns the serving target, or -1 when the request must end in an error
  function automatic int ref_route(input logic [`ADDR_W-1:0] addr);
    for (int i = `N_RULES - 1; i >= 0; i--) begin
      if (tb_valid[i] && tb_napot[i] && ((addr ^ tb_a[i]) & tb_b[i]) == '0)
        return int'(tb_idx[i]);
      if (tb_valid[i] && !tb_napot[i] && addr >= tb_a[i] && addr < tb_b[i])
        return int'(tb_idx[i]);
    end
    if (en_default_i) return int'(default_idx_i);
    return -1;
  endfunction

  // Sampled mid-cycle, where every input and output is settled
  always @(negedge clk_i) begin : monitor
    int route;
    int word;
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      checks++;
      if (exp_data.size() == 0) begin
        $display("response arrived with no request outstanding");
        errors++;
      end else begin
        if (rsp_rdata_o !== exp_data[0]) begin
          $display("FAIL rsp_rdata_o: got %h, expected %h", rsp_rdata_o, exp_data[0]);
          errors++;
        end
        if (rsp_err_o !== exp_err[0]) begin
          $display("FAIL rsp_err_o: got %h, expected %h", rsp_err_o, exp_err[0]);
          errors++;
        end
        if (chk_lat && cycle != exp_cycle[0] + 1) begin
          $display("response came in cycle %0d for a request taken in cycle %0d",
                   cycle, exp_cycle[0]);
          errors++;
        end
        void'(exp_data.pop_front());
        void'(exp_err.pop_front());
        void'(exp_cycle.pop_front());
      end
    end
    if (rst_n_i && req_valid_i && req_ready_o) begin
      route = ref_route(req_addr_i);
      word  = (int'(req_addr_i) / BYTES) % `TGT_WORDS;
      exp_cycle.push_back(cycle);
      exp_err.push_back(route < 0);
      if (route < 0 || req_we_i) begin
        exp_data.push_back('0);
      end else begin
        exp_data.push_back(model_mem[route][word]);
      end
      if (route >= 0 && req_we_i) model_mem[route][word] = req_wdata_i;
    end
  end

  task automatic set_rule(input int sel, input logic valid, input logic napot,
                          input tgt_idx_t idx, input logic [`ADDR_W-1:0] a,
                          input logic [`ADDR_W-1:0] b);
    cfg_entry_i.valid = valid;
    cfg_entry_i.napot = napot;
    cfg_entry_i.idx   = idx;
    // Range start and NAPOT base share the upper half of the rule word
    cfg_entry_i.rule.range_r.start_addr = a;
    cfg_entry_i.rule.range_r.end_addr   = b;
    cfg_sel_i = sel[$clog2(`N_RULES)-1:0];
    cfg_we_i  = 1'b1;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
    tb_valid[sel] = valid;
    tb_napot[sel] = napot;
    tb_idx[sel]   = idx;
    tb_a[sel]     = a;
    tb_b[sel]     = b;
  endtask

  // Holds the request until it transfers
  task automatic send_req(input logic we, input logic [`ADDR_W-1:0] addr,
                          input logic [`DATA_W-1:0] wdata);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain;
    while (exp_data.size() != 0) @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input string name);
    drain();
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, errors - test_base);
    test_base = errors;
  endtask

  initial begin
    logic [`ADDR_W-1:0] addr;
    logic [31:0]        rnd;
    {rst_n_i, req_valid_i, req_we_i, rsp_ready_i, cfg_we_i, en_default_i} = '0;
    req_addr_i = '0;
    req_wdata_i = '0;
    cfg_sel_i = '0;
    cfg_entry_i = '0;
    default_idx_i = '0;
    {cycle, errors, checks, test_base, n_tests} = '0;
    seed = 32'hbdde_c6cb;
    chk_lat = 1'b1;
    for (int i = 0; i < `N_RULES; i++) tb_valid[i] = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    rsp_ready_i = 1'b1;
    checks++;
    if (rsp_valid_o !== 1'b0) begin
      $display("FAIL rsp_valid_o: got %h, expected %h", rsp_valid_o, 1'b0);
      errors++;
    end
    if (req_ready_o !== 1'b1) begin
      $display("FAIL req_ready_o: got %h, expected %h", req_ready_o, 1'b1);
      errors++;
    end
    // Four disjoint 64-byte windows, one per target, filled with an address pattern
    for (int t = 0; t < `N_TGT; t++)
      set_rule(t, 1'b1, 1'b0, t, 16'h1000 * t, 16'h1000 * t + 16'h40);
    for (int t = 0; t < `N_TGT; t++) begin
      for (int w = 0; w < `TGT_WORDS; w++) begin
        addr = 16'h1000 * t + BYTES * w;
        send_req(1'b1, addr, {addr, ~addr});
      end
    end
    for (int t = 0; t < `N_TGT; t++)
      for (int w = 0; w < `TGT_WORDS; w++) send_req(1'b0, 16'h1000 * t + BYTES * w, '0);
    finish_test("disjoint ranges");
    // Rule 1 sits above rule 0 and takes the overlap for target 2
    set_rule(0, 1'b1, 1'b0, 2'd0, 16'h0000, 16'h8000);
    set_rule(1, 1'b1, 1'b0, 2'd2, 16'h2000, 16'h2040);
    set_rule(2, 1'b0, 1'b0, 2'd0, 16'h0000, 16'h0000);
    set_rule(3, 1'b0, 1'b0, 2'd0, 16'h0000, 16'h0000);
    send_req(1'b1, 16'h2008, 32'hc0de_0002);
    send_req(1'b0, 16'h2008, '0);
    send_req(1'b0, 16'h0008, '0);
    finish_test("overlapping ranges");
    // All of 0x4xxx goes to target 3, the rest falls through to rule 0 or 1
    set_rule(3, 1'b1, 1'b1, 2'd3, 16'h4000, 16'hf000);
    for (int n = 0; n < 8; n++) begin
      rnd = $random(seed);
      send_req(1'b1, 16'h4000 | (rnd[15:0] & 16'h0ffc), rnd);
      send_req(1'b0, 16'h4000 | (rnd[31:16] & 16'h0ffc), '0);
    end
    send_req(1'b1, 16'h5010, 32'h5010_5010);
    send_req(1'b0, 16'h5010, '0);
    // The same word of target 0 must now hold the write made through 0x5010
    send_req(1'b0, 16'h0010, '0);
    send_req(1'b0, 16'h2010, '0);
    finish_test("napot region");
    set_rule(1, 1'b0, 1'b0, 2'd0, 16'h0000, 16'h0000);
    set_rule(3, 1'b0, 1'b0, 2'd0, 16'h0000, 16'h0000);
    send_req(1'b0, 16'h9000, '0);
    send_req(1'b1, 16'h9004, 32'hdead_beef);
    en_default_i  = 1'b1;
    default_idx_i = 2'd1;
    send_req(1'b1, 16'h9004, 32'hfeed_0001);
    send_req(1'b0, 16'h9004, '0);
    drain();
    en_default_i = 1'b0;
    finish_test("unmapped and default");
    // Random traffic against a mixed map, with gaps that end in errors
    chk_lat = 1'b0;
    set_rule(0, 1'b1, 1'b0, 2'd0, 16'h0000, 16'h4000);
    set_rule(1, 1'b1, 1'b0, 2'd1, 16'h3000, 16'h6000);
    set_rule(2, 1'b1, 1'b1, 2'd2, 16'h5000, 16'hf800);
    set_rule(3, 1'b1, 1'b0, 2'd3, 16'h8000, 16'h9000);
    sending = 1'b1;
    fork
      begin
        for (int n = 0; n < N_RAND; n++) begin
          rnd = $random(seed);
          send_req(rnd[31], rnd[15:0] & 16'hdffc, $random(seed));
        end
        sending = 1'b0;
      end
      while (sending) begin
        @(posedge clk_i);
        #1;
        rnd = $random(seed);
        rsp_ready_i = rnd[3];
      end
    join
    rsp_ready_i = 1'b1;
    finish_test("random traffic");
    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    while (cycle < MAX_CYCLES) @(posedge clk_i);
    $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- addr_map.f
+incdir+.
rtl/addr_map_pkg.sv
rtl/tgt_link_if.sv
rtl/addr_decode.sv
rtl/req_steer.sv
rtl/mem_target.sv
rtl/rsp_merge.sv
rtl/addr_map_top.sv
dv/tb_addr_map.sv

//--- Makefile
TOP := tb_addr_map

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f addr_map.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
